// File: src/ex_pkg.sv
package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data path width
  localparam int xlen = 32;

  // Shift amount taken from operand b
  localparam int shamt_bits = 5;

  // Register file address, 6 bits to match the decode stage
  localparam int regaddr_bits = 6;

  ////////////////////
  // Data types
  ////////////////////

  typedef logic [xlen-1:0] word_t;

  typedef logic [regaddr_bits-1:0] regaddr_t;

  ////////////////////
  // Operators
  ////////////////////

  // ALU operators, arithmetic and logic first, branch compares last
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_eq   = 4'd10,
    alu_ne   = 4'd11,
    alu_lt   = 4'd12,
    alu_ge   = 4'd13,
    alu_ltu  = 4'd14,
    alu_geu  = 4'd15
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    mult_mul    = 2'd0,
    mult_mulh   = 2'd1,
    mult_mulhsu = 2'd2,
    mult_mulhu  = 2'd3
  } mult_op_e;

  // High product sequencer
  typedef enum logic [1:0] {
    mult_idle = 2'd0,
    mult_step = 2'd1,
    mult_done = 2'd2
  } mult_state_e;

endpackage

// File: src/ex_alu.sv
module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  // Adder control
  logic                          sub_mode;
  logic                          signed_cmp;
  logic [ex_pkg::xlen:0]         adder_a;
  logic [ex_pkg::xlen:0]         adder_b;
  logic [ex_pkg::xlen:0]         adder_sum;
  logic                          less;
  logic                          equal;
  logic [ex_pkg::shamt_bits-1:0] shamt;

  ////////////////////
  // Shared adder
  ////////////////////

  // Everything except add goes through the subtract path
  assign sub_mode = (operator_i != ex_pkg::alu_add);

  // Signed compares extend with the sign bit
  assign signed_cmp = (operator_i == ex_pkg::alu_slt) ||
                      (operator_i == ex_pkg::alu_lt)  ||
                      (operator_i == ex_pkg::alu_ge);

  // One extra bit so the top bit of the sum is the true sign
  assign adder_a = {signed_cmp & operand_a_i[ex_pkg::xlen-1], operand_a_i};
  assign adder_b = {signed_cmp & operand_b_i[ex_pkg::xlen-1], operand_b_i};

  // Two's complement subtract via inverted b and carry in
  assign adder_sum = adder_a + (sub_mode ? ~adder_b : adder_b) + {{ex_pkg::xlen{1'b0}}, sub_mode};

  assign less  = adder_sum[ex_pkg::xlen];
  assign equal = (operand_a_i == operand_b_i);

  // Only the low bits of b shift
  assign shamt = operand_b_i[ex_pkg::shamt_bits-1:0];

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    case (operator_i)
      ex_pkg::alu_add,
      ex_pkg::alu_sub:  result_o = adder_sum[ex_pkg::xlen-1:0];
      ex_pkg::alu_and:  result_o = operand_a_i & operand_b_i;
      ex_pkg::alu_or:   result_o = operand_a_i | operand_b_i;
      ex_pkg::alu_xor:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::alu_sll:  result_o = operand_a_i << shamt;
      ex_pkg::alu_srl:  result_o = operand_a_i >> shamt;
      ex_pkg::alu_sra:  result_o = ex_pkg::word_t'($signed(operand_a_i) >>> shamt);
      // Set-less-than and the compares return the flag in bit 0
      default:          result_o = {{(ex_pkg::xlen-1){1'b0}}, cmp_result_o};
    endcase
  end

  // Branch condition, slt/sltu fall through to the less flag
  always_comb begin
    case (operator_i)
      ex_pkg::alu_eq:  cmp_result_o = equal;
      ex_pkg::alu_ne:  cmp_result_o = ~equal;
      ex_pkg::alu_ge,
      ex_pkg::alu_geu: cmp_result_o = ~less;
      default:         cmp_result_o = less;
    endcase
  end

  // Operator must be fully driven by decode
  always_comb begin : op_known_chk
    assert (!$isunknown(operator_i))
      else $error("ex_alu: operator has unknown bits");
  end

endmodule

// File: src/ex_mult.sv
module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::word_t    op_a_i,
  input  ex_pkg::word_t    op_b_i,
  input  logic             ex_ready_i,
  output ex_pkg::word_t    result_o,
  output logic             ready_o,
  output logic             multicycle_o
);

  ex_pkg::mult_state_e state_q;
  ex_pkg::mult_state_e state_d;

  // Operand extension for the high variants
  logic                     a_sign;
  logic                     b_sign;
  logic signed [ex_pkg::xlen:0] a_ext;
  logic signed [ex_pkg::xlen:0] b_ext;
  logic signed [16:0]       b_lo;
  logic signed [16:0]       b_hi;

  // Partial products and accumulator, low 64 bits of the full product
  logic signed [2*ex_pkg::xlen-1:0] pp_lo;
  logic signed [2*ex_pkg::xlen-1:0] pp_hi;
  logic signed [2*ex_pkg::xlen-1:0] acc_q;

  logic high_op;
  logic issue_high;

  ////////////////////
  // Operand setup
  ////////////////////

  assign high_op = (operator_i != ex_pkg::mult_mul);

  // New high product starts only from idle
  assign issue_high = enable_i && high_op && (state_q == ex_pkg::mult_idle);

  // mulh and mulhsu treat a as signed, only mulh treats b as signed
  assign a_sign = op_a_i[ex_pkg::xlen-1] &&
                  ((operator_i == ex_pkg::mult_mulh) || (operator_i == ex_pkg::mult_mulhsu));
  assign b_sign = op_b_i[ex_pkg::xlen-1] && (operator_i == ex_pkg::mult_mulh);

  assign a_ext = {a_sign, op_a_i};
  assign b_ext = {b_sign, op_b_i};

  // Low half of b is always unsigned, high half carries the sign
  assign b_lo = {1'b0, b_ext[15:0]};
  assign b_hi = b_ext[ex_pkg::xlen:16];

  // Both operands sign-extend to the 64-bit context
  assign pp_lo = a_ext * b_lo;
  assign pp_hi = a_ext * b_hi;

  ////////////////////
  // Sequencer
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_pkg::mult_idle: begin
        if (issue_high) begin
          state_d = ex_pkg::mult_step;
        end
      end
      ex_pkg::mult_step: state_d = ex_pkg::mult_done;
      // Hold the result until the stage moves on
      ex_pkg::mult_done: begin
        if (ex_ready_i) begin
          state_d = ex_pkg::mult_idle;
        end
      end
      default: state_d = ex_pkg::mult_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::mult_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Accumulator, first the low-half partial then the shifted high-half partial
  always_ff @(posedge clk) begin
    if (issue_high) begin
      acc_q <= pp_lo;
    end else if (state_q == ex_pkg::mult_step) begin
      acc_q <= acc_q + (pp_hi <<< 16);
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Busy on the issue cycle and during the step
  assign ready_o = !issue_high && (state_q != ex_pkg::mult_step);

  assign multicycle_o = (state_q == ex_pkg::mult_done);

  // Upper word once done, else the plain low product
  assign result_o = (state_q == ex_pkg::mult_done) ? acc_q[2*ex_pkg::xlen-1:ex_pkg::xlen]
                                                   : op_a_i * op_b_i;

  // Decode holds the operands while the high product accumulates
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ex_pkg::mult_step) |->
      ($stable(operator_i) && $stable(op_a_i) && $stable(op_b_i)))
    else $error("ex_mult: operands changed during a high product");

endmodule

// File: src/ex_wb_reg.sv
module ex_wb_reg (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ex_valid_i,
  input  logic             wb_ready_i,
  input  logic             regfile_we_i,
  input  ex_pkg::regaddr_t regfile_waddr_i,
  input  logic             lsu_err_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  output logic             regfile_we_wb_o,
  output ex_pkg::regaddr_t regfile_waddr_wb_o,
  output ex_pkg::word_t    regfile_wdata_wb_o
);

  // Write enable with a faulting access squashed
  logic we_masked;

  ex_pkg::regaddr_t waddr_q;
  logic             we_q;

  assign we_masked = regfile_we_i & ~lsu_err_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  // Enable is control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      // Valid implies wb_ready_i
      we_q <= we_masked;
    end else if (wb_ready_i) begin
      // Writeback consumed the slot and nothing new came in
      we_q <= 1'b0;
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_i && we_masked) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;

  // Load data comes straight from the load/store unit
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: src/ex_stage.sv
module ex_stage (
  input  logic             clk,
  input  logic             rst_n,

  // ALU operands from decode
  input  ex_pkg::alu_op_e  alu_operator_i,
  input  ex_pkg::word_t    alu_operand_a_i,
  input  ex_pkg::word_t    alu_operand_b_i,
  input  ex_pkg::word_t    alu_operand_c_i,
  input  logic             alu_en_i,

  // Multiplier
  input  ex_pkg::mult_op_e mult_operator_i,
  input  ex_pkg::word_t    mult_operand_a_i,
  input  ex_pkg::word_t    mult_operand_b_i,
  input  logic             mult_en_i,
  output logic             mult_multicycle_o,

  // CSR read data
  input  logic             csr_access_i,
  input  ex_pkg::word_t    csr_rdata_i,

  // Load/store unit
  input  logic             lsu_en_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  input  logic             lsu_ready_ex_i,
  input  logic             lsu_err_i,

  input  logic             branch_in_ex_i,

  // Destination registers
  input  ex_pkg::regaddr_t regfile_alu_waddr_i,
  input  logic             regfile_alu_we_i,
  input  logic             regfile_we_i,
  input  ex_pkg::regaddr_t regfile_waddr_i,

  // Load/store write port
  output ex_pkg::regaddr_t regfile_waddr_wb_o,
  output logic             regfile_we_wb_o,
  output ex_pkg::word_t    regfile_wdata_wb_o,

  // Forwarding write port
  output ex_pkg::regaddr_t regfile_alu_waddr_fw_o,
  output logic             regfile_alu_we_fw_o,
  output ex_pkg::word_t    regfile_alu_wdata_fw_o,

  // Jump and branch to fetch
  output ex_pkg::word_t    jump_target_o,
  output logic             branch_decision_o,

  // Handshake
  output logic             ex_ready_o,
  output logic             ex_valid_o,
  input  logic             wb_ready_i
);

  ex_pkg::word_t alu_result;
  ex_pkg::word_t mult_result;
  logic          alu_cmp_result;
  logic          mult_ready;
  logic          ex_ready;
  logic          ex_valid;
  logic          units_ready;

  ex_alu alu_i (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_reg wb_reg_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid),
    .wb_ready_i         (wb_ready_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_err_i          (lsu_err_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o)
  );

  ////////////////////
  // Forwarding port
  ////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over mult, mult over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  // Branch target comes from operand c untouched
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_cmp_result;

  ////////////////////
  // Stall and valid
  ////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Valid never looks at ready
  assign ex_valid = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // Branches resolve here and never wait on writeback
  assign ex_ready = units_ready | branch_in_ex_i;

  assign ex_valid_o = ex_valid;
  assign ex_ready_o = ex_ready;

  // Decode issues to one result source at a time
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, mult_en_i, csr_access_i}))
    else $error("ex_stage: more than one of alu, mult and csr enabled");

endmodule

// File: bench/ex_checker.sv
module ex_checker (
  input  logic             clk,
  input  logic             rst_n,

  // Decode side, same names as on the DUT
  input  ex_pkg::alu_op_e  alu_operator_i,
  input  ex_pkg::word_t    alu_operand_a_i,
  input  ex_pkg::word_t    alu_operand_b_i,
  input  ex_pkg::word_t    alu_operand_c_i,
  input  logic             alu_en_i,
  input  ex_pkg::mult_op_e mult_operator_i,
  input  ex_pkg::word_t    mult_operand_a_i,
  input  ex_pkg::word_t    mult_operand_b_i,
  input  logic             mult_en_i,
  input  logic             csr_access_i,
  input  ex_pkg::word_t    csr_rdata_i,
  input  logic             lsu_en_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  input  logic             lsu_ready_ex_i,
  input  logic             lsu_err_i,
  input  logic             branch_in_ex_i,
  input  ex_pkg::regaddr_t regfile_alu_waddr_i,
  input  logic             regfile_alu_we_i,
  input  logic             regfile_we_i,
  input  ex_pkg::regaddr_t regfile_waddr_i,
  input  logic             wb_ready_i,

  // DUT outputs under check
  input  logic             mult_multicycle_i,
  input  ex_pkg::regaddr_t regfile_waddr_wb_i,
  input  logic             regfile_we_wb_i,
  input  ex_pkg::word_t    regfile_wdata_wb_i,
  input  ex_pkg::regaddr_t regfile_alu_waddr_fw_i,
  input  logic             regfile_alu_we_fw_i,
  input  ex_pkg::word_t    regfile_alu_wdata_fw_i,
  input  ex_pkg::word_t    jump_target_i,
  input  logic             branch_decision_i,
  input  logic             ex_ready_i,
  input  logic             ex_valid_i,

  output int               check_count_o,
  output int               error_count_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int checks = 0;
  int errors = 0;

  // Model state for the high product sequence and the EX/WB register
  ex_pkg::mult_state_e mphase     = ex_pkg::mult_idle;
  logic                wb_we_q    = 1'b0;
  ex_pkg::regaddr_t    wb_waddr_q = '0;

  assign check_count_o = checks;
  assign error_count_o = errors;

  ////////////////////
  // Reference model
  ////////////////////

  // Branch condition, lt doubles as slt and ltu as sltu
  function automatic logic branch_model(input ex_pkg::alu_op_e op,
                                        input ex_pkg::word_t a,
                                        input ex_pkg::word_t b);
    case (op)
      ex_pkg::alu_eq:   return a == b;
      ex_pkg::alu_ne:   return a != b;
      ex_pkg::alu_ge:   return $signed(a) >= $signed(b);
      ex_pkg::alu_geu:  return a >= b;
      ex_pkg::alu_sltu,
      ex_pkg::alu_ltu:  return a < b;
      default:          return $signed(a) < $signed(b);
    endcase
  endfunction

  function automatic ex_pkg::word_t alu_model(input ex_pkg::alu_op_e op,
                                              input ex_pkg::word_t a,
                                              input ex_pkg::word_t b);
    case (op)
      ex_pkg::alu_add: return a + b;
      ex_pkg::alu_sub: return a - b;
      ex_pkg::alu_and: return a & b;
      ex_pkg::alu_or:  return a | b;
      ex_pkg::alu_xor: return a ^ b;
      // Shift amount is the low five bits of b
      ex_pkg::alu_sll: return a << b[4:0];
      ex_pkg::alu_srl: return a >> b[4:0];
      ex_pkg::alu_sra: return ex_pkg::word_t'($signed(a) >>> b[4:0]);
      // Set-less-than and compares give the flag in bit 0
      default:         return {31'b0, branch_model(op, a, b)};
    endcase
  endfunction

  // Upper word of the 64-bit product with per-operator extension
  function automatic ex_pkg::word_t mulh_model(input ex_pkg::mult_op_e op,
                                               input ex_pkg::word_t a,
                                               input ex_pkg::word_t b);
    logic [63:0] wide_a;
    logic [63:0] wide_b;
    logic [63:0] prod;
    wide_a = {{32{a[31] && (op != ex_pkg::mult_mulhu)}}, a};
    wide_b = {{32{b[31] && (op == ex_pkg::mult_mulh)}}, b};
    prod   = wide_a * wide_b;
    return prod[63:32];
  endfunction

  task automatic check_value(input string name,
                             input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  ////////////////////
  // Comparison
  ////////////////////

  // Inputs move on the rising edge, so the falling edge sees settled values
  always @(negedge clk) begin : sample
    logic busy;
    logic units_ready;
    logic exp_valid;
    logic exp_ready;
    if (!rst_n) begin
      check_value("regfile_we_wb_o", 1'b0, regfile_we_wb_i);
      check_value("mult_multicycle_o", 1'b0, mult_multicycle_i);
      mphase     = ex_pkg::mult_idle;
      wb_we_q    = 1'b0;
      wb_waddr_q = '0;
    end else begin
      // Multiplier stalls on the issue cycle of a high product and on the step
      busy = (mphase == ex_pkg::mult_step) ||
             (mphase == ex_pkg::mult_idle && mult_en_i &&
              mult_operator_i != ex_pkg::mult_mul);
      units_ready = !busy && lsu_ready_ex_i && wb_ready_i;
      exp_valid   = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && units_ready;
      exp_ready   = units_ready || branch_in_ex_i;

      check_value("ex_valid_o", exp_valid, ex_valid_i);
      check_value("ex_ready_o", exp_ready, ex_ready_i);
      check_value("mult_multicycle_o", mphase == ex_pkg::mult_done, mult_multicycle_i);

      // Passthrough paths
      check_value("regfile_alu_we_fw_o", regfile_alu_we_i, regfile_alu_we_fw_i);
      check_value("regfile_alu_waddr_fw_o", regfile_alu_waddr_i, regfile_alu_waddr_fw_i);
      check_value("jump_target_o", alu_operand_c_i, jump_target_i);
      check_value("regfile_wdata_wb_o", lsu_rdata_i, regfile_wdata_wb_i);

      // Forwarding data, csr then mult then alu
      if (csr_access_i) begin
        check_value("regfile_alu_wdata_fw_o", csr_rdata_i, regfile_alu_wdata_fw_i);
      end else if (mult_en_i && mult_operator_i == ex_pkg::mult_mul) begin
        check_value("regfile_alu_wdata_fw_o", mult_operand_a_i * mult_operand_b_i,
                    regfile_alu_wdata_fw_i);
      end else if (mult_en_i && mphase == ex_pkg::mult_done) begin
        check_value("regfile_alu_wdata_fw_o",
                    mulh_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i),
                    regfile_alu_wdata_fw_i);
      end else if (alu_en_i) begin
        check_value("regfile_alu_wdata_fw_o",
                    alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
                    regfile_alu_wdata_fw_i);
      end

      if (alu_operator_i >= ex_pkg::alu_eq) begin
        check_value("branch_decision_o",
                    branch_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
                    branch_decision_i);
      end

      // Load/store write port from last cycle
      check_value("regfile_we_wb_o", wb_we_q, regfile_we_wb_i);
      if (wb_we_q) begin
        check_value("regfile_waddr_wb_o", wb_waddr_q, regfile_waddr_wb_i);
      end

      // Next EX/WB state, a load/store error squashes the write
      if (exp_valid) begin
        wb_we_q = regfile_we_i && !lsu_err_i;
        if (wb_we_q) begin
          wb_waddr_q = regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        wb_we_q = 1'b0;
      end

      // Next multiplier phase, done waits for the stage to move on
      case (mphase)
        ex_pkg::mult_idle: begin
          if (busy) begin
            mphase = ex_pkg::mult_step;
          end
        end
        ex_pkg::mult_step: mphase = ex_pkg::mult_done;
        default: begin
          if (exp_ready) begin
            mphase = ex_pkg::mult_idle;
          end
        end
      endcase
    end
  end

endmodule

// File: bench/ex_tb.sv
module ex_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_ops        = 2000;
  localparam int clk_period   = 40;
  localparam int reset_cycles = 10;
  // Four cycles per operation leaves room for high products under back-pressure
  localparam longint timeout_ns = longint'(n_ops) * 4 * clk_period + reset_cycles * clk_period;

  logic clk   = 1'b0;
  logic rst_n = 1'b0;

  // Decode side inputs
  ex_pkg::alu_op_e  alu_operator_i      = ex_pkg::alu_add;
  ex_pkg::word_t    alu_operand_a_i     = '0;
  ex_pkg::word_t    alu_operand_b_i     = '0;
  ex_pkg::word_t    alu_operand_c_i     = '0;
  logic             alu_en_i            = 1'b0;
  ex_pkg::mult_op_e mult_operator_i     = ex_pkg::mult_mul;
  ex_pkg::word_t    mult_operand_a_i    = '0;
  ex_pkg::word_t    mult_operand_b_i    = '0;
  logic             mult_en_i           = 1'b0;
  logic             csr_access_i        = 1'b0;
  ex_pkg::word_t    csr_rdata_i         = '0;
  logic             lsu_en_i            = 1'b0;
  logic             branch_in_ex_i      = 1'b0;
  ex_pkg::regaddr_t regfile_alu_waddr_i = '0;
  logic             regfile_alu_we_i    = 1'b0;
  logic             regfile_we_i        = 1'b0;
  ex_pkg::regaddr_t regfile_waddr_i     = '0;

  // Load/store unit and writeback side
  ex_pkg::word_t    lsu_rdata_i         = '0;
  logic             lsu_ready_ex_i      = 1'b1;
  logic             lsu_err_i           = 1'b0;
  logic             wb_ready_i          = 1'b1;

  // DUT outputs
  logic             mult_multicycle_o;
  ex_pkg::regaddr_t regfile_waddr_wb_o;
  logic             regfile_we_wb_o;
  ex_pkg::word_t    regfile_wdata_wb_o;
  ex_pkg::regaddr_t regfile_alu_waddr_fw_o;
  logic             regfile_alu_we_fw_o;
  ex_pkg::word_t    regfile_alu_wdata_fw_o;
  ex_pkg::word_t    jump_target_o;
  logic             branch_decision_o;
  logic             ex_ready_o;
  logic             ex_valid_o;

  int          check_count;
  int          error_count;
  int          issued    = 0;
  logic [31:0] lcg_state = 32'h6cf1;

  always #(clk_period / 2) clk = ~clk;

  ex_stage dut_i (.*);

  ex_checker check_i (
    .*,
    .mult_multicycle_i      (mult_multicycle_o),
    .regfile_waddr_wb_i     (regfile_waddr_wb_o),
    .regfile_we_wb_i        (regfile_we_wb_o),
    .regfile_wdata_wb_i     (regfile_wdata_wb_o),
    .regfile_alu_waddr_fw_i (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw_o),
    .regfile_alu_wdata_fw_i (regfile_alu_wdata_fw_o),
    .jump_target_i          (jump_target_o),
    .branch_decision_i      (branch_decision_o),
    .ex_ready_i             (ex_ready_o),
    .ex_valid_i             (ex_valid_o),
    .check_count_o          (check_count),
    .error_count_o          (error_count)
  );

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Numerical Recipes LCG, state moves on every call
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Downstream readiness and load response change every cycle, mostly favorable
  task automatic update_downstream();
    logic [31:0] r;
    r = next_random();
    wb_ready_i     <= (r[31:29] != 3'd0);
    lsu_ready_ex_i <= (r[28:26] != 3'd0);
    lsu_err_i      <= (r[25:23] == 3'd0);
    lsu_rdata_i    <= next_random();
  endtask

  // One new operation from decode, exactly one result source
  task automatic issue_operation();
    logic [31:0]     r;
    logic [31:0]     s;
    ex_pkg::alu_op_e op;
    ex_pkg::word_t   a;
    r  = next_random();
    s  = next_random();
    op = ex_pkg::alu_op_e'(r[31:28]);
    a  = next_random();
    alu_operator_i      <= op;
    alu_operand_a_i     <= a;
    // Equal operands now and then so eq and ne go both ways
    alu_operand_b_i     <= (r[27:26] == 2'd0) ? a : next_random();
    alu_operand_c_i     <= next_random();
    mult_operator_i     <= ex_pkg::mult_op_e'(r[25:24]);
    mult_operand_a_i    <= next_random();
    mult_operand_b_i    <= next_random();
    csr_rdata_i         <= next_random();
    alu_en_i            <= (r[23:22] == 2'd0);
    mult_en_i           <= (r[23:22] == 2'd1);
    csr_access_i        <= (r[23:22] == 2'd2);
    lsu_en_i            <= (r[23:22] == 2'd3);
    // Branches only ride on ALU compares
    branch_in_ex_i      <= (r[23:22] == 2'd0) && (op >= ex_pkg::alu_eq) && r[21];
    regfile_we_i        <= s[31];
    regfile_waddr_i     <= ex_pkg::regaddr_t'(s[30:25]);
    regfile_alu_we_i    <= s[24];
    regfile_alu_waddr_i <= ex_pkg::regaddr_t'(s[23:18]);
  endtask

  // Bubble from decode
  task automatic clear_operation();
    alu_en_i         <= 1'b0;
    mult_en_i        <= 1'b0;
    csr_access_i     <= 1'b0;
    lsu_en_i         <= 1'b0;
    branch_in_ex_i   <= 1'b0;
    regfile_we_i     <= 1'b0;
    regfile_alu_we_i <= 1'b0;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    // One extra round drains the last operation into a bubble
    while (issued <= n_ops) begin
      @(posedge clk);
      update_downstream();
      // Decode moves on only when EX took the current operation
      if (ex_ready_o) begin
        if (issued < n_ops) begin
          issue_operation();
        end else begin
          clear_operation();
        end
        issued++;
      end
    end
    repeat (4) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: src.f
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_wb_reg.sv
src/ex_stage.sv
bench/ex_checker.sv
bench/ex_tb.sv

// File: run.sh
#!/bin/sh
# Build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module ex_tb -f src.f -o ex_tb_sim

# Keep the log even when the simulator exits with an error
status=0
./obj_dir/ex_tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
